//--- rtl/grid_pkg.sv
package grid_pkg;

    // Grid geometry
    localparam int grid_size   = 28;
    localparam int cell_pixels = 4;
    localparam int grid_cells  = grid_size * grid_size;

    typedef logic [9:0]                     cell_addr_t;  // row * 28 + column
    typedef logic [4:0]                     coord_t;
    typedef logic [$clog2(cell_pixels)-1:0] offset_t;     // Pixel offset inside a cell
    typedef logic signed [31:0]             pixel_word_t; // Zero means empty

    // PS/2 arrow scan codes
    localparam logic [7:0] key_left  = 8'h6b;
    localparam logic [7:0] key_right = 8'h74;
    localparam logic [7:0] key_up    = 8'h75;
    localparam logic [7:0] key_down  = 8'h72;

    localparam int ps2_bits = 11;  // start, 8 data, parity, stop

    localparam logic [1:0] ps2_idle  = 2'd0;
    localparam logic [1:0] ps2_shift = 2'd1;
    localparam logic [1:0] ps2_check = 2'd2;

    // About 40 ms at 50 MHz
    localparam int holdoff_default = 2_000_000;
    typedef logic [20:0] holdoff_t;

    typedef logic [2:0] colour_t;
    localparam colour_t colour_cursor = 3'b100;
    localparam colour_t colour_set    = 3'b010;
    localparam colour_t colour_empty  = 3'b011;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cursor_t;

    typedef struct packed {
        logic        en;
        cell_addr_t  addr;
        pixel_word_t data;
    } cell_write_t;

    typedef struct packed {
        logic       plot;
        logic [7:0] x;
        logic [6:0] y;
        colour_t    colour;
    } pixel_out_t;

    // Bits arrive LSB first, so the start bit ends up at the bottom
    typedef struct packed {
        logic       stop;
        logic       parity;
        logic [7:0] code;
        logic       start;
    } ps2_fields_t;

    typedef union packed {
        logic [ps2_bits-1:0] raw;
        ps2_fields_t         f;
    } ps2_frame_u;

    function automatic cell_addr_t cell_addr(input coord_t col, input coord_t row);
        return cell_addr_t'(row * grid_size + col);
    endfunction

endpackage

//--- rtl/ps2_receiver.sv
`timescale 1ns/10ps

module ps2_receiver import grid_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       reset_f,
    input  logic       on,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] code,
    output logic       code_valid
);

    logic [7:0] filter;
    logic       clk_filt;
    logic       clk_filt_next;
    logic       fall_edge;
    logic       shift_en;
    logic [1:0] state;
    logic [3:0] bits_left;
    ps2_frame_u frame;

    // Filtered clock only flips once 8 samples agree
    assign clk_filt_next = (filter == 8'hff) ? 1'b1 :
                           (filter == 8'h00) ? 1'b0 : clk_filt;
    assign fall_edge     = clk_filt & ~clk_filt_next;

    // No new bits while the finished frame is checked
    assign shift_en = fall_edge && (state == ps2_idle || state == ps2_shift);

    always_ff @(posedge CLOCK_50) begin
        if (on && shift_en) begin
            frame.raw <= {ps2_dat, frame.raw[ps2_bits-1:1]};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset_f) begin
            filter     <= '0;
            clk_filt   <= 1'b0;
            state      <= ps2_idle;
            bits_left  <= '0;
            code       <= '0;
            code_valid <= 1'b0;
        end else if (on) begin
            filter     <= {ps2_clk, filter[7:1]};
            clk_filt   <= clk_filt_next;
            code_valid <= 1'b0;
            case (state)
                ps2_idle: begin
                    if (shift_en) begin
                        bits_left <= 4'(ps2_bits - 2);  // Ten bits still to come
                        state     <= ps2_shift;
                    end
                end
                ps2_shift: begin
                    if (shift_en) begin
                        bits_left <= bits_left - 1'b1;
                        if (bits_left == '0)
                            state <= ps2_check;
                    end
                end
                ps2_check: begin
                    // Parity is not checked
                    if (!frame.f.start && frame.f.stop) begin
                        code       <= frame.f.code;
                        code_valid <= 1'b1;
                    end
                    state <= ps2_idle;
                end
                default: state <= ps2_idle;
            endcase
        end
    end

endmodule

//--- rtl/cursor_control.sv
`timescale 1ns/10ps

module cursor_control import grid_pkg::*; #(
    parameter int holdoff_cycles = holdoff_default
) (
    input  logic        CLOCK_50,
    input  logic        reset_f,
    input  logic        on,
    input  logic [7:0]  code,
    input  logic        code_valid,
    input  logic        draw,
    output cursor_t     cursor,
    output cell_write_t wr
);

    holdoff_t holdoff;

    always_ff @(posedge CLOCK_50) begin
        if (reset_f) begin
            cursor  <= '0;
            holdoff <= '0;
            wr      <= '0;
        end else if (on) begin
            if (holdoff == '0) begin
                // Write goes to the cell under the cursor before any move
                wr.en   <= draw;
                wr.addr <= cell_addr(cursor.x, cursor.y);
                wr.data <= pixel_word_t'(1);
                if (code_valid) begin
                    case (code)
                        key_left: if (cursor.x != '0) begin
                            cursor.x <= cursor.x - 1'b1;
                            holdoff  <= holdoff_t'(holdoff_cycles);
                        end
                        key_right: if (cursor.x != coord_t'(grid_size - 1)) begin
                            cursor.x <= cursor.x + 1'b1;
                            holdoff  <= holdoff_t'(holdoff_cycles);
                        end
                        key_up: if (cursor.y != '0) begin
                            cursor.y <= cursor.y - 1'b1;
                            holdoff  <= holdoff_t'(holdoff_cycles);
                        end
                        key_down: if (cursor.y != coord_t'(grid_size - 1)) begin
                            cursor.y <= cursor.y + 1'b1;
                            holdoff  <= holdoff_t'(holdoff_cycles);
                        end
                        default: ;  // Other keys do nothing
                    endcase
                end
            end else begin
                holdoff <= holdoff - 1'b1;  // Codes ignored while counting
                wr.en   <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/grid_memory.sv
`timescale 1ns/10ps

module grid_memory import grid_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        on,
    input  cell_write_t wr,
    input  cell_addr_t  scan_addr,
    input  cell_addr_t  infer_addr,
    output pixel_word_t scan_data,
    output pixel_word_t infer_data
);

    pixel_word_t mem [grid_cells];

    // Empty grid at power-up
    initial begin
        for (int i = 0; i < grid_cells; i++)
            mem[i] = '0;
    end

    always_ff @(posedge CLOCK_50) begin
        if (on && wr.en)
            mem[wr.addr] <= wr.data;
    end

    // Scanner and classifier ports run independently
    always_ff @(posedge CLOCK_50) begin
        scan_data  <= mem[scan_addr];
        infer_data <= mem[infer_addr];
    end

endmodule

//--- rtl/grid_scanner.sv
`timescale 1ns/10ps

module grid_scanner import grid_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        reset_f,
    input  logic        on,
    input  cursor_t     cursor,
    input  pixel_word_t scan_data,
    output cell_addr_t  scan_addr,
    output pixel_out_t  pixel
);

    coord_t  col, row;
    offset_t xo, yo;
    logic    active;  // Low for the gap cycle between frames

    // Stage aligned with the memory read data
    coord_t  col_d, row_d;
    offset_t xo_d, yo_d;
    logic    valid_d;

    logic    is_cursor;

    assign scan_addr = cell_addr(col, row);
    assign is_cursor = (col_d == cursor.x) && (row_d == cursor.y);

    always_ff @(posedge CLOCK_50) begin
        if (reset_f) begin
            col     <= '0;
            row     <= '0;
            xo      <= '0;
            yo      <= '0;
            active  <= 1'b0;
            valid_d <= 1'b0;
            pixel   <= '0;
        end else if (on) begin
            if (!active) begin
                active <= 1'b1;
            end else if (xo != offset_t'(cell_pixels - 1)) begin
                xo <= xo + 1'b1;
            end else begin
                xo <= '0;
                if (yo != offset_t'(cell_pixels - 1)) begin
                    yo <= yo + 1'b1;
                end else begin
                    yo <= '0;
                    if (col != coord_t'(grid_size - 1)) begin
                        col <= col + 1'b1;
                    end else begin
                        col <= '0;
                        if (row != coord_t'(grid_size - 1)) begin
                            row <= row + 1'b1;
                        end else begin
                            row    <= '0;
                            active <= 1'b0;  // Frame done
                        end
                    end
                end
            end

            col_d   <= col;
            row_d   <= row;
            xo_d    <= xo;
            yo_d    <= yo;
            valid_d <= active;

            pixel.plot   <= valid_d;
            pixel.x      <= {1'b0, col_d, xo_d};
            pixel.y      <= {row_d, yo_d};
            pixel.colour <= is_cursor           ? colour_cursor :
                            (scan_data != '0)  ? colour_set    : colour_empty;
        end
    end

endmodule

//--- rtl/hex_encoder.sv
`timescale 1ns/10ps

module hex_encoder import grid_pkg::*; (
    input  cursor_t    cursor,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3
);

    // Active-low segments, gfedcba
    function automatic logic [6:0] seg(input logic [3:0] v);
        case (v)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    assign hex0 = seg(cursor.x[3:0]);
    assign hex1 = seg({3'b000, cursor.x[4]});  // Column high digit
    assign hex2 = seg(cursor.y[3:0]);
    assign hex3 = seg({3'b000, cursor.y[4]});

endmodule

//--- rtl/drawing_grid_top.sv
`timescale 1ns/10ps

module drawing_grid_top import grid_pkg::*; #(
    parameter int holdoff_cycles = holdoff_default
) (
    input  logic        CLOCK_50,
    input  logic        reset_f,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    input  logic        draw,
    input  logic        on,
    input  cell_addr_t  infer_addr,
    output pixel_word_t infer_data,
    output pixel_out_t  pixel,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3
);

    logic [7:0]  code;
    logic        code_valid;
    cursor_t     cursor;
    cell_write_t wr;
    cell_addr_t  scan_addr;
    pixel_word_t scan_data;

    ps2_receiver u_ps2 (
        .CLOCK_50   (CLOCK_50),
        .reset_f    (reset_f),
        .on         (on),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .code       (code),
        .code_valid (code_valid)
    );

    cursor_control #(.holdoff_cycles(holdoff_cycles)) u_cursor (
        .CLOCK_50   (CLOCK_50),
        .reset_f    (reset_f),
        .on         (on),
        .code       (code),
        .code_valid (code_valid),
        .draw       (draw),
        .cursor     (cursor),
        .wr         (wr)
    );

    grid_memory u_mem (
        .CLOCK_50   (CLOCK_50),
        .on         (on),
        .wr         (wr),
        .scan_addr  (scan_addr),
        .infer_addr (infer_addr),
        .scan_data  (scan_data),
        .infer_data (infer_data)
    );

    grid_scanner u_scan (
        .CLOCK_50  (CLOCK_50),
        .reset_f   (reset_f),
        .on        (on),
        .cursor    (cursor),
        .scan_data (scan_data),
        .scan_addr (scan_addr),
        .pixel     (pixel)
    );

    // Cursor column on hex1:hex0, row on hex3:hex2
    hex_encoder u_hex (
        .cursor (cursor),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3)
    );

endmodule

//--- sim/tb_drawing_grid.sv
`timescale 1ns/10ps

module tb_drawing_grid import grid_pkg::*; ();

    localparam int tb_holdoff   = 40;
    localparam int ps2_half     = 30;   // System cycles per PS/2 clock half
    localparam int settle       = 60;   // Longer than the hold-off
    localparam int frame_side   = grid_size * cell_pixels;
    localparam int frame_cycles = frame_side * frame_side + 1;
    localparam int key_cycles   = 11 * (2 * ps2_half + 1) + 1 + settle;
    localparam int max_keys     = 200;
    localparam int watchdog_cycles = (8 * frame_cycles + max_keys * key_cycles) * 6 / 5;

    logic        CLOCK_50;
    logic        reset_f;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        draw;
    logic        on;
    cell_addr_t  infer_addr;
    pixel_word_t infer_data;
    pixel_out_t  pixel;
    logic [6:0]  hex0, hex1, hex2, hex3;

    integer  seed;
    int      n_checks;
    int      n_errors;
    cursor_t exp_cur;                 // Cursor model
    bit      drawn [grid_cells];
    colour_t frame_col [frame_side][frame_side];
    bit      seen [frame_side][frame_side];

    drawing_grid_top #(.holdoff_cycles(tb_holdoff)) dut0 (
        .CLOCK_50   (CLOCK_50),
        .reset_f    (reset_f),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .draw       (draw),
        .on         (on),
        .infer_addr (infer_addr),
        .infer_data (infer_data),
        .pixel      (pixel),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // Active-low gfedcba pattern back to its digit, -1 if none
    function automatic int seg_value(input logic [6:0] s);
        case (s)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h08: return 10;
            7'h03: return 11;
            7'h46: return 12;
            7'h21: return 13;
            7'h06: return 14;
            7'h0e: return 15;
            default: return -1;
        endcase
    endfunction

    function automatic cursor_t next_cursor(input cursor_t c, input logic [7:0] k);
        cursor_t n;
        n = c;
        if (k == key_left && c.x != 0)
            n.x = c.x - 1'b1;
        else if (k == key_right && c.x != coord_t'(grid_size - 1))
            n.x = c.x + 1'b1;
        else if (k == key_up && c.y != 0)
            n.y = c.y - 1'b1;
        else if (k == key_down && c.y != coord_t'(grid_size - 1))
            n.y = c.y + 1'b1;
        return n;
    endfunction

    task automatic check_cursor(input cursor_t exp, input string what);
        int d0, d1, d2, d3;
        int got_x, got_y;
        d0 = seg_value(hex0);
        d1 = seg_value(hex1);
        d2 = seg_value(hex2);
        d3 = seg_value(hex3);
        n_checks++;
        if (d0 < 0 || d1 < 0 || d2 < 0 || d3 < 0) begin
            n_errors++;
            $display("ERROR at %0t ns: %s: hex outputs show no valid digit", $time, what);
        end else begin
            got_x = d1 * 16 + d0;
            got_y = d3 * 16 + d2;
            if (got_x != exp.x || got_y != exp.y) begin
                n_errors++;
                $display("ERROR at %0t ns: %s: cursor (%0d,%0d), expected (%0d,%0d)",
                         $time, what, got_x, got_y, exp.x, exp.y);
            end
        end
    endtask

    task automatic check_word(input pixel_word_t got, input pixel_word_t exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_colour(input colour_t got, input colour_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t ns: %s: colour %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input pixel_out_t got, input pixel_out_t exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t ns: %s: pixel %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_key(input logic [7:0] k, input logic stop_bit);
        logic [10:0] bits;
        bits = {stop_bit, ~^k, k, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50) ps2_dat <= bits[i];
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
        @(posedge CLOCK_50) ps2_dat <= 1'b1;
    endtask

    task automatic press_key(input logic [7:0] k, input logic good);
        send_key(k, good);
        repeat (settle) @(posedge CLOCK_50);
        if (good)
            exp_cur = next_cursor(exp_cur, k);
        check_cursor(exp_cur, $sformatf("after key %h", k));
    endtask

    task automatic move_to(input coord_t col, input coord_t row);
        while (exp_cur.x < col) press_key(key_right, 1'b1);
        while (exp_cur.x > col) press_key(key_left, 1'b1);
        while (exp_cur.y < row) press_key(key_down, 1'b1);
        while (exp_cur.y > row) press_key(key_up, 1'b1);
    endtask

    task automatic check_read(input int a, input pixel_word_t exp);
        @(posedge CLOCK_50) infer_addr <= cell_addr_t'(a);
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_word(infer_data, exp, $sformatf("infer_data at address %0d", a));
    endtask

    task automatic test_reset();
        @(negedge CLOCK_50);
        n_checks++;
        if (pixel.plot !== 1'b0) begin
            n_errors++;
            $display("ERROR at %0t ns: plot is high right after reset", $time);
        end
        check_cursor('0, "reset state");
        check_read($unsigned($random(seed)) % grid_cells, '0);
    endtask

    task automatic test_cursor();
        press_key(key_left, 1'b1);   // Both at the edge
        press_key(key_up, 1'b1);
        repeat (3) press_key(key_right, 1'b1);
        repeat (2) press_key(key_down, 1'b1);
        press_key(key_left, 1'b1);
        press_key(key_up, 1'b1);
        press_key(key_right, 1'b0);  // Bad stop bit
    endtask

    task automatic test_holdoff();
        send_key(key_down, 1'b1);
        exp_cur = next_cursor(exp_cur, key_down);
        @(posedge CLOCK_50) on <= 1'b0;  // Hold-off still counting here
        send_key(key_right, 1'b1);
        @(posedge CLOCK_50) on <= 1'b1;
        repeat (settle) @(posedge CLOCK_50);
        check_cursor(exp_cur, "key sent in hold-off with on low");
    endtask

    task automatic test_enable();
        pixel_out_t held;
        @(posedge CLOCK_50) on <= 1'b0;
        @(negedge CLOCK_50);
        held = pixel;
        for (int i = 0; i < 20; i++) begin
            @(posedge CLOCK_50) draw <= (i < 15);
            @(negedge CLOCK_50);
            check_pixel(pixel, held, "pixel while on is low");
        end
        @(posedge CLOCK_50) on <= 1'b1;
        repeat (3) @(posedge CLOCK_50);
        check_read(exp_cur.y * grid_size + exp_cur.x, '0);
    endtask

    task automatic test_drawing();
        int a;
        for (int k = 0; k < 3; k++) begin
            move_to(coord_t'($unsigned($random(seed)) % grid_size),
                    coord_t'($unsigned($random(seed)) % grid_size));
            @(posedge CLOCK_50) draw <= 1'b1;
            repeat (3) @(posedge CLOCK_50);
            draw <= 1'b0;
            drawn[exp_cur.y * grid_size + exp_cur.x] = 1'b1;
            repeat (3) @(posedge CLOCK_50);
        end
        for (int i = 0; i < grid_cells; i++)
            if (drawn[i])
                check_read(i, pixel_word_t'(1));
        for (int i = 0; i < 4; i++) begin
            a = $unsigned($random(seed)) % grid_cells;
            while (drawn[a])
                a = (a + 1) % grid_cells;
            check_read(a, '0);
        end
    endtask

    // Pixel monitor for one whole frame, starting after the gap cycle
    task automatic capture_frame(output int count);
        count = 0;
        for (int x = 0; x < frame_side; x++)
            for (int y = 0; y < frame_side; y++)
                seen[x][y] = 1'b0;
        @(negedge CLOCK_50);
        while (pixel.plot) @(negedge CLOCK_50);
        while (!pixel.plot) @(negedge CLOCK_50);
        while (pixel.plot) begin
            if (pixel.x < frame_side && pixel.y < frame_side) begin
                frame_col[pixel.x][pixel.y] = pixel.colour;
                seen[pixel.x][pixel.y]      = 1'b1;
            end else begin
                n_errors++;
                $display("ERROR at %0t ns: pixel (%0d,%0d) outside the grid",
                         $time, pixel.x, pixel.y);
            end
            count++;
            @(negedge CLOCK_50);
        end
    endtask

    task automatic test_frame();
        int      count;
        int      col, row;
        colour_t exp;
        capture_frame(count);
        n_checks++;
        if (count != frame_side * frame_side) begin
            n_errors++;
            $display("ERROR at %0t ns: frame has %0d plotted pixels, expected %0d",
                     $time, count, frame_side * frame_side);
        end
        for (int x = 0; x < frame_side; x++) begin
            for (int y = 0; y < frame_side; y++) begin
                col = x / cell_pixels;
                row = y / cell_pixels;
                if (col == exp_cur.x && row == exp_cur.y)
                    exp = colour_cursor;
                else if (drawn[row * grid_size + col])
                    exp = colour_set;
                else
                    exp = colour_empty;
                if (!seen[x][y]) begin
                    n_errors++;
                    $display("Pixel (%0d,%0d) was never plotted in the frame", x, y);
                end else begin
                    check_colour(frame_col[x][y], exp, $sformatf("pixel (%0d,%0d)", x, y));
                end
            end
        end
    endtask

    initial begin
        seed       = 32'h3c50_e337;
        n_checks   = 0;
        n_errors   = 0;
        exp_cur    = '0;
        reset_f    = 1'b1;
        on         = 1'b1;
        ps2_clk    = 1'b1;  // PS/2 lines idle high
        ps2_dat    = 1'b1;
        draw       = 1'b0;
        infer_addr = '0;
        repeat (2) @(posedge CLOCK_50);
        reset_f <= 1'b0;

        test_reset();
        test_cursor();
        test_holdoff();
        test_enable();
        test_drawing();
        test_frame();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        $display("Timeout: the tests were still running after %0d clock cycles",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sources.f
rtl/grid_pkg.sv
rtl/ps2_receiver.sv
rtl/cursor_control.sv
rtl/grid_memory.sv
rtl/grid_scanner.sv
rtl/hex_encoder.sv
rtl/drawing_grid_top.sv
sim/tb_drawing_grid.sv

//--- Bender.yml
package:
  name: drawing_grid

sources:
  - rtl/grid_pkg.sv
  - rtl/ps2_receiver.sv
  - rtl/cursor_control.sv
  - rtl/grid_memory.sv
  - rtl/grid_scanner.sv
  - rtl/hex_encoder.sv
  - rtl/drawing_grid_top.sv
  - target: simulation
    files:
      - sim/tb_drawing_grid.sv
